// ==== hdl/uart_defs.svh ====
// sizing macros shared by the UART peripheral
// include wherever a width, tick count or FIFO size is needed
// baudDivisor is kept small so that simulation runs stay short

`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

////////////////////////////////////////
// serial frame
////////////////////////////////////////

`define dataBits 8		// bits per frame, LSB first
`define sbTick 16		// oversampling ticks in the stop period, one stop bit

////////////////////////////////////////
// FIFOs
////////////////////////////////////////

`define fifoDepth 16		// entries per FIFO
`define fifoCntrWidth 5		// occupancy counter, holds 0 to fifoDepth

////////////////////////////////////////
// baud rate
////////////////////////////////////////

// clk cycles per oversampling tick
// 16 ticks per bit so one bit is 64 clk at the default
`define baudDivisor 4

`endif

// ==== hdl/uartLinePkg.sv ====
// types for the serial line side of the UART
// engine state encodings and the status word read by UARTstat
// imported by the receiver, the transmitter and the peripheral top

package uartLinePkg;

	// receiver FSM
	typedef enum logic [1:0]
	{
		rxIdle     = 2'b00,		// waiting for a low rx
		rxStartBit = 2'b01,		// counting to mid start bit
		rxDataBit  = 2'b10,		// sampling data mid bit
		rxStopBit  = 2'b11		// waiting out the stop period
	} rxState_t;

	// transmitter FSM, mirrors the receiver
	typedef enum logic [1:0]
	{
		txIdle     = 2'b00,
		txStartBit = 2'b01,
		txDataBit  = 2'b10,
		txStopBit  = 2'b11
	} txState_t;

	// status byte, high bit first
	typedef struct packed
	{
		logic [2:0] spare;		// always zero
		logic rxOverrun;		// sticky, cleared by a status read
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxEmpty;
	} uartStatus_t;

endpackage

// ==== hdl/uartCmdPkg.sv ====
// types for the processor facing command port of the UART
// one command per strobe, mirroring UARTrd, UARTwr and UARTstat
// driven by the processor control unit or by a testbench

`include "uart_defs.svh"

package uartCmdPkg;

	// uart opcodes
	typedef enum logic [1:0]
	{
		opNone  = 2'b00,		// no access
		opRead  = 2'b01,		// UARTrd, pop receive FIFO
		opWrite = 2'b10,		// UARTwr, push transmit FIFO
		opStat  = 2'b11			// UARTstat, read and clear overrun
	} uartOp_t;

	// one command, qualified by cmdStrobe at the top
	typedef struct packed
	{
		uartOp_t op;
		logic [`dataBits-1:0] wrData;		// only meaningful for opWrite
	} uartCmd_t;

endpackage

// ==== hdl/baudGen.sv ====
// oversampling tick generator for both UART engines
// sTick is a one cycle pulse every divisor clk cycles
// change divisor here to retune the baud rate, the engines only count ticks

`timescale 1ns/1ps
`include "uart_defs.svh"

module baudGen
#(
	parameter int divisor = `baudDivisor
)
(
	input logic clk,
	input logic reset,
	output logic sTick
);

	localparam int cntW = (divisor > 1) ? $clog2(divisor) : 1;

	logic [cntW-1:0] cntReg;		// free running divide counter

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			cntReg <= '0;
		else if (cntReg == cntW'(divisor - 1))
			cntReg <= '0;		// wrap
		else
			cntReg <= cntReg + 1'b1;
	end

	// pulse on the wrap count
	assign sTick = (cntReg == cntW'(divisor - 1));

endmodule

// ==== hdl/uartRec.sv ====
// 16x oversampling UART receiver, 8N1 LSB first
// leaves idle on the first low rx, samples each data bit mid bit
// rxDoneTick pulses for one cycle once the stop period has been counted
// dOut holds the last frame until the next one starts shifting in
// no stop bit level check, no start bit recheck

`timescale 1ns/1ps
`include "uart_defs.svh"

module uartRec import uartLinePkg::*;
#(
	parameter int dataBits = `dataBits,
	parameter int sbTick = `sbTick
)
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,
	output logic rxDoneTick,
	output logic [dataBits-1:0] dOut
);

	localparam int sW = ($clog2(sbTick) > 4) ? $clog2(sbTick) : 4;
	localparam int nW = (dataBits > 1) ? $clog2(dataBits) : 1;

	rxState_t stateReg, stateNext;
	logic [sW-1:0] sReg, sNext;		// tick counter within a bit
	logic [nW-1:0] nReg, nNext;		// data bit counter
	logic [dataBits-1:0] bReg;		// shift register
	logic shift;		// take one sample this cycle
	logic doneNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= rxIdle;
			sReg <= '0;
			nReg <= '0;
			rxDoneTick <= 1'b0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			rxDoneTick <= doneNext;		// one cycle after the last stop tick
		end
	end

	// data shifts in from the top, ends LSB aligned
	always_ff @(posedge clk)
	begin
		if (shift)
			bReg <= {rx, bReg[dataBits-1:1]};
	end

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		shift = 1'b0;
		doneNext = 1'b0;
		case (stateReg)
			rxIdle:
				if (!rx)
				begin
					stateNext = rxStartBit;		// falling edge seen
					sNext = '0;
				end
			rxStartBit:
				if (sTick)
				begin
					if (sReg == sW'(7))
					begin
						stateNext = rxDataBit;		// mid start bit
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			rxDataBit:
				if (sTick)
				begin
					if (sReg == sW'(15))
					begin
						sNext = '0;
						shift = 1'b1;		// mid data bit
						if (nReg == nW'(dataBits - 1))
							stateNext = rxStopBit;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			rxStopBit:
				if (sTick)
				begin
					if (sReg == sW'(sbTick - 1))
					begin
						stateNext = rxIdle;
						doneNext = 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = rxIdle;
		endcase
	end

	assign dOut = bReg;

	// done only follows the last stop tick, and never back to back
	doneAfterStop: assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> $past(stateReg == rxStopBit && sTick));
	doneSingle: assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |=> !rxDoneTick);

endmodule

// ==== hdl/uartTrans.sv ====
// UART transmitter, 8N1 LSB first, counted in oversampling ticks
// txStart latches din, the start bit goes out on the next cycle
// each bit lasts 16 sTicks, the stop period lasts sbTick
// txDoneTick pulses once the stop period is over, busy is high outside idle

`timescale 1ns/1ps
`include "uart_defs.svh"

module uartTrans import uartLinePkg::*;
#(
	parameter int dataBits = `dataBits,
	parameter int sbTick = `sbTick
)
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic txStart,
	input logic [dataBits-1:0] din,
	output logic tx,
	output logic txDoneTick,
	output logic busy
);

	localparam int sW = ($clog2(sbTick) > 4) ? $clog2(sbTick) : 4;
	localparam int nW = (dataBits > 1) ? $clog2(dataBits) : 1;

	txState_t stateReg, stateNext;
	logic [sW-1:0] sReg, sNext;		// ticks within a bit
	logic [nW-1:0] nReg, nNext;		// bits sent
	logic [dataBits-1:0] bReg;		// outgoing byte, bit 0 is on the line
	logic txReg, txNext;		// registered line, no glitches
	logic load, shift, doneNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= txIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;		// line idles high
			txDoneTick <= 1'b0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
			txDoneTick <= doneNext;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			bReg <= din;
		else if (shift)
			bReg <= bReg >> 1;
	end

	////////////////////////////////////////
	// next state and line level
	////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		txNext = txReg;
		load = 1'b0;
		shift = 1'b0;
		doneNext = 1'b0;
		case (stateReg)
			txIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					stateNext = txStartBit;
					sNext = '0;
					txNext = 1'b0;		// start bit next cycle
					load = 1'b1;
				end
			end
			txStartBit:
				if (sTick)
				begin
					if (sReg == sW'(15))
					begin
						stateNext = txDataBit;
						sNext = '0;
						nNext = '0;
						txNext = bReg[0];		// LSB first
					end
					else
						sNext = sReg + 1'b1;
				end
			txDataBit:
				if (sTick)
				begin
					if (sReg == sW'(15))
					begin
						sNext = '0;
						shift = 1'b1;
						if (nReg == nW'(dataBits - 1))
						begin
							stateNext = txStopBit;
							txNext = 1'b1;		// stop level
						end
						else
						begin
							nNext = nReg + 1'b1;
							txNext = bReg[1];		// bit after the shift
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			txStopBit:
				if (sTick)
				begin
					if (sReg == sW'(sbTick - 1))
					begin
						stateNext = txIdle;
						doneNext = 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = txIdle;
		endcase
	end

	assign tx = txReg;
	assign busy = (stateReg != txIdle);

	idleLineHigh: assert property (@(posedge clk) disable iff (reset)
		(stateReg == txIdle) |-> tx);

endmodule

// ==== hdl/uartFifo.sv ====
// first word fall through FIFO between a UART engine and the command port
// rdData always shows the head entry, rd pops it
// a write when full and a read when empty are dropped
// read and write together while full is legal, count stays put

`timescale 1ns/1ps
`include "uart_defs.svh"

module uartFifo
#(
	parameter int depth = `fifoDepth
)
(
	input logic clk,
	input logic reset,
	input logic wr,
	input logic rd,
	input logic [`dataBits-1:0] wrData,
	output logic [`dataBits-1:0] rdData,
	output logic empty,
	output logic full
);

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;

	logic [`dataBits-1:0] mem [depth];
	logic [ptrW-1:0] wrPtr, rdPtr;
	logic [`fifoCntrWidth-1:0] count;		// occupancy, 0 to depth
	logic doWr, doRd;

	assign doRd = rd && !empty;
	assign doWr = wr && (!full || rd);		// full slot frees up on the same edge

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWr)
				wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
			if (doRd)
				rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
			if (doWr && !doRd)
				count <= count + 1'b1;
			else if (doRd && !doWr)
				count <= count - 1'b1;
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (doWr)
			mem[wrPtr] <= wrData;
	end

	assign rdData = mem[rdPtr];		// head, stale when empty
	assign empty = (count == '0);
	assign full = (count == `fifoCntrWidth'(depth));

	countBound: assert property (@(posedge clk) disable iff (reset)
		count <= `fifoCntrWidth'(depth));

endmodule

// ==== hdl/uartPeripheral.sv ====
// UART peripheral of the instruction list processor
// serves UARTrd, UARTwr and UARTstat through cmd and cmdStrobe
// rdData answers combinationally in the strobe cycle
// receive path rx to rxFifo, transmit path txFifo to tx
// rxOverrun is sticky until the next status read

`timescale 1ns/1ps
`include "uart_defs.svh"

module uartPeripheral import uartLinePkg::*, uartCmdPkg::*;
(
	input logic clk,
	input logic reset,
	input logic cmdStrobe,
	input logic rx,
	input uartCmd_t cmd,
	output logic [`dataBits-1:0] rdData,
	output logic tx
);

	logic sTick;
	logic rxDoneTick, rxEmpty, rxFull, rxPop;
	logic [`dataBits-1:0] rxByte, rxHead;
	logic txStart, txBusy, txEmpty, txFull, txPush;
	logic [`dataBits-1:0] txHead;
	logic rxOverrun;
	uartStatus_t status;

	////////////////////////////////////////
	// command decode
	////////////////////////////////////////

	assign rxPop = cmdStrobe && (cmd.op == opRead);
	assign txPush = cmdStrobe && (cmd.op == opWrite);

	always_comb
	begin
		case (cmd.op)
			opRead: rdData = rxHead;		// head before the pop
			opStat: rdData = status;
			default: rdData = '0;
		endcase
	end

	// sticky overrun where a lost byte wins over a clear in the same cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rxOverrun <= 1'b0;
		else if (rxDoneTick && rxFull)
			rxOverrun <= 1'b1;
		else if (cmdStrobe && (cmd.op == opStat))
			rxOverrun <= 1'b0;
	end

	assign status = '{spare: 3'b000, rxOverrun: rxOverrun, txFull: txFull,
		txEmpty: txEmpty, rxFull: rxFull, rxEmpty: rxEmpty};

	// start a frame as soon as a byte waits and the line is free
	assign txStart = !txEmpty && !txBusy;

	////////////////////////////////////////
	// blocks
	////////////////////////////////////////

	baudGen baudGen0 (.clk, .reset, .sTick);

	uartRec uartRec0 (.clk, .reset, .sTick, .rx, .rxDoneTick, .dOut(rxByte));

	uartFifo rxFifo (.clk, .reset, .wr(rxDoneTick), .rd(rxPop), .wrData(rxByte),
		.rdData(rxHead), .empty(rxEmpty), .full(rxFull));

	uartFifo txFifo (.clk, .reset, .wr(txPush), .rd(txStart), .wrData(cmd.wrData),
		.rdData(txHead), .empty(txEmpty), .full(txFull));

	uartTrans uartTrans0 (.clk, .reset, .sTick, .txStart, .din(txHead), .tx,
		.txDoneTick(), .busy(txBusy));

endmodule

// ==== verification/uartTb.sv ====
// testbench for the UART peripheral
// plays the steps in verification/uart_vectors.txt against dut0
// acts as the serial partner on rx and rebuilds the frames seen on tx

`timescale 1ns/1ps
`include "uart_defs.svh"

module uartTb import uartCmdPkg::*;
();

	logic clk, reset, cmdStrobe, rx, tx;
	uartCmd_t cmd;
	logic [`dataBits-1:0] rdData;

	int errors, checks, stepErrs;
	logic timedOut;
	logic [9:0] txFrames [$];		// {stop, data, start} as seen on tx

	uartPeripheral dut0 (.clk, .reset, .cmdStrobe, .rx, .cmd, .rdData, .tx);

	always #4 clk = ~clk;		// 8 ns period

	////////////////////////////////////////
	// tx monitor
	////////////////////////////////////////

	always
	begin : txMonitor
		logic [9:0] frameBits;
		@(negedge clk);
		if (!reset && tx === 1'b0)
		begin
			repeat (32) @(negedge clk);		// mid start bit
			frameBits[0] = tx;
			for (int i = 1; i < 10; i++)
			begin
				repeat (64) @(negedge clk);		// one bit later
				frameBits[i] = tx;
			end
			txFrames.push_back(frameBits);		// back to idle at mid stop
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// inputs always change 1 ns after the edge
	task automatic waitCycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic checkValue(input logic [8*16-1:0] name, input logic [9:0] expected,
		input logic [9:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("FAIL %0s expected %0h actual %0h", name, expected, actual);
			errors++;
			stepErrs++;
		end
	endtask

	task automatic reportTimeout(input logic [8*16-1:0] name, input string what);
		$display("step %0s timed out, %0s", name, what);
		errors++;
		stepErrs++;
		timedOut = 1'b1;
	endtask

	// one strobed command with rdData sampled once it settles
	task automatic issueCmd(input uartOp_t op, input logic [7:0] data,
		output logic [7:0] resp);
		int gap;
		cmd.op = op;
		cmd.wrData = data;
		cmdStrobe = 1'b1;
		#1 resp = rdData;
		waitCycles(1);
		cmdStrobe = 1'b0;
		cmd.op = opNone;
		gap = $urandom % 4;		// idle cycles before the next command
		waitCycles(gap);
	endtask

	// 8N1 frame on rx at 64 clk per bit
	task automatic sendFrame(input logic [8*16-1:0] name, input logic [7:0] data);
		logic [8:0] bits;
		int waited;
		bits = {data, 1'b0};		// start bit goes first
		for (int i = 0; i < 9; i++)
		begin
			rx = bits[i];
			waitCycles(64);
		end
		rx = 1'b1;		// stop
		waited = 0;
		while (dut0.rxDoneTick !== 1'b1 && waited < 160)
		begin
			waitCycles(1);
			waited++;
		end
		if (dut0.rxDoneTick !== 1'b1)
			reportTimeout(name, "the receiver never signalled a finished frame");
		else if (waited < 64)
			waitCycles(64 - waited);		// finish the stop bit
	endtask

	task automatic runStep(input logic [8*8-1:0] kind, input logic [8*16-1:0] name,
		input logic [7:0] data, input logic [7:0] expStat, input int reps);
		logic [7:0] cur, resp;
		logic [9:0] frame;
		int waited, lowCycles;
		for (int k = 0; k < reps && !timedOut; k++)
		begin
			cur = data + 8'(k);		// byte steps by one per repeat
			if (kind == "send")
				sendFrame(name, cur);
			else if (kind == "write")
				issueCmd(opWrite, cur, resp);
			else if (kind == "read")
			begin
				issueCmd(opRead, '0, resp);
				checkValue(name, {2'b00, cur}, {2'b00, resp});
			end
			else if (kind == "stat")
			begin
				issueCmd(opStat, '0, resp);
				checkValue(name, {2'b00, expStat}, {2'b00, resp});
			end
			else if (kind == "txcheck")
			begin
				waited = 0;
				while (txFrames.size() == 0 && waited < 2000)
				begin
					waitCycles(1);
					waited++;
				end
				if (txFrames.size() == 0)
					reportTimeout(name, "no frame came out on tx");
				else
				begin
					frame = txFrames.pop_front();
					checkValue(name, {1'b1, cur, 1'b0}, frame);		// high stop, low start
				end
			end
			else if (kind == "quiet")
			begin
				lowCycles = 0;
				for (int c = 0; c < 800; c++)
				begin
					waitCycles(1);
					if (tx !== 1'b1)
						lowCycles++;
				end
				checkValue(name, 10'd0, 10'(lowCycles));		// line never left idle
				checkValue(name, 10'd0, 10'(txFrames.size()));
			end
			else
			begin
				$display("step %0s has an unknown kind %0s", name, kind);
				errors++;
				stepErrs++;
			end
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		int fd, n;
		logic [8*128-1:0] lineBuf;
		logic [8*8-1:0] kind;
		logic [8*16-1:0] name;
		logic [7:0] data, expStat;
		int reps;
		errors = 0;
		checks = 0;
		timedOut = 1'b0;
		void'($urandom(13196));
		clk = 1'b0;
		reset = 1'b1;
		rx = 1'b1;		// line idles high
		cmdStrobe = 1'b0;
		cmd = '{op: opNone, wrData: '0};
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;

		fd = $fopen("verification/uart_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("the vector file could not be opened");
			errors++;
		end
		else
		begin
			while (!$feof(fd) && !timedOut)
			begin
				lineBuf = '0;
				kind = '0;
				name = '0;
				n = $fgets(lineBuf, fd);
				n = $sscanf(lineBuf, "%s %s %h %h %d", kind, name, data, expStat, reps);
				if (n == 5 && kind != "#")		// comments and blanks skipped
				begin
					stepErrs = 0;
					runStep(kind, name, data, expStat, reps);
					if (stepErrs == 0)
						$display("PASS %0s", name);
				end
			end
			$fclose(fd);
		end

		$display("%0d checks run, %0d failures", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/uartLinePkg.sv
hdl/uartCmdPkg.sv
hdl/baudGen.sv
hdl/uartRec.sv
hdl/uartTrans.sv
hdl/uartFifo.sv
hdl/uartPeripheral.sv
verification/uartTb.sv

// ==== verification/uart_vectors.txt ====
# columns: kind name byte status count
# status is the expected status word for stat, count repeats the step with byte stepping by one
quiet   reset_line    00 00 1
stat    reset_status  00 05 1
send    rx_send_a5    a5 00 1
send    rx_send_3c    3c 00 1
send    rx_send_0f    0f 00 1
stat    rx_pending    00 04 1
read    rx_read_a5    a5 00 1
stat    rx_two_left   00 04 1
read    rx_read_3c    3c 00 1
stat    rx_one_left   00 04 1
read    rx_read_0f    0f 00 1
stat    rx_drained    00 05 1
write   tx_write_55   55 00 1
write   tx_write_81   81 00 1
write   tx_write_f0   f0 00 1
txcheck tx_frame_55   55 00 1
txcheck tx_frame_81   81 00 1
txcheck tx_frame_f0   f0 00 1
quiet   tx_idle       00 00 1
stat    tx_drained    00 05 1
send    ovf_fill      40 00 17
stat    ovf_status    00 16 1
read    ovf_data      40 00 16
stat    ovf_cleared   00 05 1
write   txf_fill      60 00 18
stat    txf_status    00 09 1
txcheck txf_frames    60 00 17
quiet   txf_dropped   00 00 1
stat    txf_drained   00 05 1
